// File: logic/spy_hunter_cfg.svh
`ifndef SPY_HUNTER_CFG_SVH
`define SPY_HUNTER_CFG_SVH

// ========================================
// download image layout, byte addresses
// ========================================

// main cpu and sound board roms sit below the sound deluxe area
`define SH_CSD_BASE           19'h10000

// sound deluxe roms are interleaved into 16 bit words
`define SH_SPRITE_BASE        19'h18000

// background and character roms follow, not kept here
`define SH_SPRITE_END         19'h38000

// ========================================
// driver controls
// ========================================

// pedal and steering change per video frame
`define SH_GAS_STEP           8
`define SH_STEER_STEP         4

// steering level with the wheel released
`define SH_STEER_CENTER       8'h80

// ========================================
// reset sequencing
// ========================================

`define SH_SECOND_RESET_DELAY 64

`endif

// File: logic/spy_hunter_pkg.sv
package spy_hunter_pkg;

	// ========================================
	// download channel
	// ========================================

	typedef logic [18:0] dl_addr_t;
	typedef logic [7:0]  dl_byte_t;

	// ========================================
	// rom banks
	// ========================================

	typedef logic [15:0] rom_word_t;
	typedef logic [15:0] bank_addr_t;

	// index of a 32 bit sprite word, i.e. a pair of bank words
	typedef logic [14:0] sprite_addr_t;
	typedef logic [31:0] sprite_word_t;

	// pedal or steering level handed to the core
	typedef logic [7:0]  ctrl_level_t;

	// core reset sequencer
	typedef enum logic [1:0] {
		st_wait_rom,
		st_delay,
		st_run
	} rst_state_t;

endpackage

// File: logic/rom_loader.sv
`timescale 1ns/10ps

`include "spy_hunter_cfg.svh"

module rom_loader import spy_hunter_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ioctl_download,
	input  logic       ioctl_wr,
	input  dl_byte_t   ioctl_index,
	input  dl_addr_t   ioctl_addr,
	input  dl_byte_t   ioctl_dout,
	output logic       prog_req,
	output bank_addr_t prog_word,
	output logic       prog_lane,
	output dl_byte_t   prog_data,
	output logic       sprite_req,
	output bank_addr_t sprite_word,
	output logic       sprite_lane,
	output dl_byte_t   sprite_data
);

	// strobe history and the byte captured with it
	logic     wr_d;
	logic     wr_d2;
	logic     qual_d;
	dl_addr_t addr_d;
	dl_byte_t dout_d;

	logic       strobe;
	logic       in_low;
	logic       in_csd;
	logic       in_sprite;
	dl_addr_t   sprite_off;
	bank_addr_t low_word;
	bank_addr_t csd_word;
	bank_addr_t spr_word;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_d   <= 1'b0;
			wr_d2  <= 1'b0;
			qual_d <= 1'b0;
		end else begin
			wr_d   <= ioctl_wr;
			wr_d2  <= wr_d;
			qual_d <= ioctl_download && (ioctl_index == '0);
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_d <= ioctl_addr;
		dout_d <= ioctl_dout;
	end

	// rising edge of the host write, only for the rom image index
	assign strobe = wr_d && !wr_d2 && qual_d;

	// ========================================
	// region decode and remapping
	// ========================================

	assign in_low    = addr_d < `SH_CSD_BASE;
	assign in_csd    = !in_low && (addr_d < `SH_SPRITE_BASE);
	// anything at or past the sprite end falls through all three
	assign in_sprite = !in_low && !in_csd && (addr_d < `SH_SPRITE_END);

	assign sprite_off = addr_d - `SH_SPRITE_BASE;

	// byte roms pack two bytes per word
	assign low_word = {1'b0, addr_d[15:1]};
	// csd byte pairs interleave on bit 14
	assign csd_word = {addr_d[16], addr_d[15], addr_d[13:0]};
	// four sprite roms form one 32 bit word from two bank words
	assign spr_word = {sprite_off[14:0], sprite_off[16]};

	// one toggle per accepted byte, only on the bank that owns it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			prog_req   <= 1'b0;
			sprite_req <= 1'b0;
		end else if (strobe) begin
			if (in_low || in_csd) begin
				prog_req <= ~prog_req;
			end
			if (in_sprite) begin
				sprite_req <= ~sprite_req;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (strobe && (in_low || in_csd)) begin
			prog_word <= in_low ? low_word : csd_word;
			prog_lane <= in_low ? addr_d[0] : addr_d[14];
			prog_data <= dout_d;
		end
		if (strobe && in_sprite) begin
			sprite_word <= spr_word;
			sprite_lane <= sprite_off[15];
			sprite_data <= dout_d;
		end
	end

endmodule

// File: logic/rom_store.sv
`timescale 1ns/10ps

module rom_store import spy_hunter_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         prog_req,
	input  bank_addr_t   prog_word,
	input  logic         prog_lane,
	input  dl_byte_t     prog_data,
	input  logic         sprite_req,
	input  bank_addr_t   sprite_word,
	input  logic         sprite_lane,
	input  dl_byte_t     sprite_data,
	input  bank_addr_t   prog_addr,
	input  sprite_addr_t sprite_addr,
	output logic         prog_ack,
	output logic         sprite_ack,
	output rom_word_t    prog_q,
	output sprite_word_t sprite_q
);

	rom_word_t prog_mem [0:65535];
	// sprite bank split by word bit 0 so both halves of a pair read at once
	rom_word_t sprite_even [0:32767];
	rom_word_t sprite_odd [0:32767];

	logic prog_wr;
	logic sprite_wr;

	// a pending toggle means one byte to write
	assign prog_wr   = prog_req != prog_ack;
	assign sprite_wr = sprite_req != sprite_ack;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			prog_ack   <= 1'b0;
			sprite_ack <= 1'b0;
		end else begin
			prog_ack   <= prog_req;
			sprite_ack <= sprite_req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prog_wr) begin
			if (prog_lane) begin
				prog_mem[prog_word][15:8] <= prog_data;
			end else begin
				prog_mem[prog_word][7:0] <= prog_data;
			end
		end
		prog_q <= prog_mem[prog_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (sprite_wr && sprite_word[0]) begin
			if (sprite_lane) begin
				sprite_odd[sprite_word[15:1]][15:8] <= sprite_data;
			end else begin
				sprite_odd[sprite_word[15:1]][7:0] <= sprite_data;
			end
		end
		if (sprite_wr && !sprite_word[0]) begin
			if (sprite_lane) begin
				sprite_even[sprite_word[15:1]][15:8] <= sprite_data;
			end else begin
				sprite_even[sprite_word[15:1]][7:0] <= sprite_data;
			end
		end
		// odd word on top
		sprite_q <= {sprite_odd[sprite_addr], sprite_even[sprite_addr]};
	end

endmodule

// File: logic/reset_sequencer.sv
`timescale 1ns/10ps

`include "spy_hunter_cfg.svh"

module reset_sequencer import spy_hunter_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic user_reset,
	input  logic ioctl_download,
	output logic core_reset
);

	localparam int CNT_W = $clog2(`SH_SECOND_RESET_DELAY + 1);

	rst_state_t       state;
	logic             dl_d;
	logic             hold;
	logic [CNT_W-1:0] delay_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_wait_rom;
			dl_d  <= 1'b0;
			hold  <= 1'b1;
		end else begin
			dl_d <= ioctl_download;
			if (ioctl_download) begin
				// a new image invalidates the running core
				state <= st_wait_rom;
				hold  <= 1'b1;
			end else if (user_reset && (state != st_wait_rom)) begin
				state     <= st_delay;
				hold      <= 1'b1;
				// hold is still high on the first delay edge, so count one more
				delay_cnt <= CNT_W'(`SH_SECOND_RESET_DELAY);
			end else begin
				case (state)
					st_wait_rom: begin
						if (dl_d) begin
							state     <= st_delay;
							hold      <= 1'b0;
							delay_cnt <= CNT_W'(`SH_SECOND_RESET_DELAY - 1);
						end
					end
					st_delay: begin
						// second pulse once the delay has run out
						hold <= (delay_cnt == '0);
						if (delay_cnt == '0) begin
							state <= st_run;
						end else begin
							delay_cnt <= delay_cnt - 1'b1;
						end
					end
					default: begin
						hold <= 1'b0;
					end
				endcase
			end
		end
	end

	// held while the board reset is applied
	assign core_reset = reset | hold;

endmodule

// File: logic/driver_controls.sv
`timescale 1ns/10ps

`include "spy_hunter_cfg.svh"

module driver_controls import spy_hunter_pkg::*; (
	input  logic        clk_sys,
	input  logic        core_reset,
	input  logic        vsync,
	input  logic        gas_up,
	input  logic        gas_down,
	input  logic        steer_left,
	input  logic        steer_right,
	input  logic        shift_button,
	input  logic        coin,
	output ctrl_level_t gas,
	output ctrl_level_t steering,
	output logic        shift_state
);

	localparam ctrl_level_t GAS_STEP   = ctrl_level_t'(`SH_GAS_STEP);
	localparam ctrl_level_t STEER_STEP = ctrl_level_t'(`SH_STEER_STEP);
	localparam ctrl_level_t LEVEL_MAX  = 8'hff;
	localparam ctrl_level_t LEVEL_MIN  = 8'h00;

	logic        vsync_d;
	logic        shift_d;
	logic        frame_tick;
	logic        shift_press;
	ctrl_level_t gas_next;
	ctrl_level_t steer_next;

	// move one step toward target without passing it
	function automatic ctrl_level_t step_toward(
		input ctrl_level_t level,
		input ctrl_level_t target,
		input ctrl_level_t step
	);
		ctrl_level_t result;
		if (level < target) begin
			result = ((target - level) > step) ? level + step : target;
		end else if (level > target) begin
			result = ((level - target) > step) ? level - step : target;
		end else begin
			result = level;
		end
		return result;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			vsync_d <= 1'b0;
			shift_d <= 1'b0;
		end else begin
			vsync_d <= vsync;
			shift_d <= shift_button;
		end
	end

	assign frame_tick  = vsync && !vsync_d;
	assign shift_press = shift_button && !shift_d;

	// ========================================
	// pedal and steering ramps
	// ========================================

	// up wins over down, no button keeps the pedal where it is
	always_comb begin
		if (gas_up) begin
			gas_next = step_toward(gas, LEVEL_MAX, GAS_STEP);
		end else if (gas_down) begin
			gas_next = step_toward(gas, LEVEL_MIN, GAS_STEP);
		end else begin
			gas_next = gas;
		end
	end

	// a released wheel drifts back to center
	always_comb begin
		if (steer_right) begin
			steer_next = step_toward(steering, LEVEL_MAX, STEER_STEP);
		end else if (steer_left) begin
			steer_next = step_toward(steering, LEVEL_MIN, STEER_STEP);
		end else begin
			steer_next = step_toward(steering, `SH_STEER_CENTER, STEER_STEP);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			gas      <= LEVEL_MIN;
			steering <= `SH_STEER_CENTER;
		end else if (frame_tick) begin
			gas      <= gas_next;
			steering <= steer_next;
		end
	end

	// ========================================
	// gear latch
	// ========================================

	// coin drops back to low gear for a new game
	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			shift_state <= 1'b0;
		end else if (coin) begin
			shift_state <= 1'b0;
		end else if (shift_press) begin
			shift_state <= ~shift_state;
		end
	end

endmodule

// File: logic/spy_hunter_io.sv
`timescale 1ns/10ps

module spy_hunter_io import spy_hunter_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         user_reset,
	// host download channel
	input  logic         ioctl_download,
	input  logic         ioctl_wr,
	input  dl_byte_t     ioctl_index,
	input  dl_addr_t     ioctl_addr,
	input  dl_byte_t     ioctl_dout,
	// core rom reads
	input  bank_addr_t   prog_addr,
	output rom_word_t    prog_q,
	input  sprite_addr_t sprite_addr,
	output sprite_word_t sprite_q,
	// pad and cabinet inputs
	input  logic         vsync,
	input  logic         gas_up,
	input  logic         gas_down,
	input  logic         steer_left,
	input  logic         steer_right,
	input  logic         shift_button,
	input  logic         coin,
	output ctrl_level_t  gas,
	output ctrl_level_t  steering,
	output logic         shift_state,
	output logic         core_reset
);

	// loader to store, one toggle handshake per bank
	logic       prog_req;
	logic       prog_ack;
	bank_addr_t prog_word;
	logic       prog_lane;
	dl_byte_t   prog_data;
	logic       sprite_req;
	logic       sprite_ack;
	bank_addr_t sprite_word;
	logic       sprite_lane;
	dl_byte_t   sprite_data;

	rom_loader rom_loader_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.prog_req       (prog_req),
		.prog_word      (prog_word),
		.prog_lane      (prog_lane),
		.prog_data      (prog_data),
		.sprite_req     (sprite_req),
		.sprite_word    (sprite_word),
		.sprite_lane    (sprite_lane),
		.sprite_data    (sprite_data)
	);

	rom_store rom_store_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.prog_req    (prog_req),
		.prog_word   (prog_word),
		.prog_lane   (prog_lane),
		.prog_data   (prog_data),
		.sprite_req  (sprite_req),
		.sprite_word (sprite_word),
		.sprite_lane (sprite_lane),
		.sprite_data (sprite_data),
		.prog_addr   (prog_addr),
		.sprite_addr (sprite_addr),
		.prog_ack    (prog_ack),
		.sprite_ack  (sprite_ack),
		.prog_q      (prog_q),
		.sprite_q    (sprite_q)
	);

	reset_sequencer reset_sequencer_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.user_reset     (user_reset),
		.ioctl_download (ioctl_download),
		.core_reset     (core_reset)
	);

	// controls restart with the core, not with the board
	driver_controls driver_controls_inst (
		.clk_sys      (clk_sys),
		.core_reset   (core_reset),
		.vsync        (vsync),
		.gas_up       (gas_up),
		.gas_down     (gas_down),
		.steer_left   (steer_left),
		.steer_right  (steer_right),
		.shift_button (shift_button),
		.coin         (coin),
		.gas          (gas),
		.steering     (steering),
		.shift_state  (shift_state)
	);

endmodule

// File: test/spy_hunter_io_assert.sv
`timescale 1ns/10ps

module spy_hunter_io_assert import spy_hunter_pkg::*; (
	input logic        clk_sys,
	input logic        reset,
	input logic        core_reset,
	input logic        prog_req,
	input logic        prog_ack,
	input logic        sprite_req,
	input logic        sprite_ack,
	input logic        vsync,
	input ctrl_level_t gas,
	input ctrl_level_t steering
);

	// ========================================
	// toggle handshake
	// ========================================

	prog_ack_follows: assert property (@(posedge clk_sys) disable iff (reset)
		(prog_req != prog_ack) |=> (prog_ack == prog_req))
		else $error("prog ack did not follow req");

	sprite_ack_follows: assert property (@(posedge clk_sys) disable iff (reset)
		(sprite_req != sprite_ack) |=> (sprite_ack == sprite_req))
		else $error("sprite ack did not follow req");

	// ========================================
	// reset and frame timing
	// ========================================

	// the sequencer keeps the core held once the board reset lets go
	core_held_in_reset: assert property (@(posedge clk_sys) reset |=> core_reset)
		else $error("core_reset low right after board reset");

	// levels move only on the edge that sees a new vsync rise
	levels_on_frame: assert property (@(posedge clk_sys) disable iff (reset || core_reset)
		(($changed(gas) || $changed(steering)) && !$past(core_reset))
		|-> ($past(vsync) && !$past(vsync, 2)))
		else $error("control level changed outside a frame edge");

endmodule

// File: test/tb_spy_hunter_io.sv
`timescale 1ns/10ps

`include "spy_hunter_cfg.svh"

module tb_spy_hunter_io import spy_hunter_pkg::*; ();

	localparam int IMG_LEN = `SH_SPRITE_END;
	localparam int SPR_BASE = `SH_SPRITE_BASE;
	// 4 cycles per byte, every read, control frames and reset waits, plus 20 percent
	localparam int RUN_CYCLES = (IMG_LEN + 32) * 4 + 49152 + 32768 + 4200 + 600;
	localparam int CYCLE_LIMIT = RUN_CYCLES * 12 / 10;

	logic clk_sys, reset, user_reset;
	logic ioctl_download, ioctl_wr;
	dl_byte_t ioctl_index, ioctl_dout;
	dl_addr_t ioctl_addr;
	bank_addr_t prog_addr;
	rom_word_t prog_q;
	sprite_addr_t sprite_addr;
	sprite_word_t sprite_q;
	logic vsync, gas_up, gas_down, steer_left, steer_right, shift_button, coin;
	ctrl_level_t gas, steering;
	logic shift_state, core_reset;

	logic [7:0] img [0:IMG_LEN-1];
	logic [31:0] lfsr;
	int cycles;
	logic ctrl_check;
	ctrl_level_t exp_gas, exp_steer;

	spy_hunter_io spy_hunter_io_inst (.*);

	bind spy_hunter_io spy_hunter_io_assert spy_hunter_io_assert_inst (
		.clk_sys(clk_sys), .reset(reset), .core_reset(core_reset),
		.prog_req(prog_req), .prog_ack(prog_ack),
		.sprite_req(sprite_req), .sprite_ack(sprite_ack),
		.vsync(vsync), .gas(gas), .steering(steering)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: no result after %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$fatal(1);
		end
	end

	// ========================================
	// reference models
	// ========================================

	// taps 32 22 2 1 with the new bit entering at the bottom
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic rom_word_t ref_prog_word(input int w);
		int a;
		if (w < 'h8000) begin
			return {img[2 * w + 1], img[2 * w]};
		end
		// csd lane picks the byte rom through address bit 14
		a = 'h10000 + (w & 'h3fff);
		return {img[a + 'h4000], img[a]};
	endfunction

	function automatic rom_word_t bank_word(input int j);
		int s;
		s = ((j & 1) << 16) | (j >> 1);
		return {img[SPR_BASE + s + 'h8000], img[SPR_BASE + s]};
	endfunction

	function automatic sprite_word_t ref_sprite_word(input int i);
		return {bank_word(2 * i + 1), bank_word(2 * i)};
	endfunction

	// pad bits are {up, down, left, right}
	// result packs {gas, steering}
	function automatic logic [15:0] ref_controls(input logic [15:0] cur, input logic [3:0] pad);
		int g;
		int s;
		g = int'(cur[15:8]);
		s = int'(cur[7:0]);
		if (pad[3]) g = (g + `SH_GAS_STEP > 255) ? 255 : g + `SH_GAS_STEP;
		else if (pad[2]) g = (g < `SH_GAS_STEP) ? 0 : g - `SH_GAS_STEP;
		if (pad[0]) s = (s + `SH_STEER_STEP > 255) ? 255 : s + `SH_STEER_STEP;
		else if (pad[1]) s = (s < `SH_STEER_STEP) ? 0 : s - `SH_STEER_STEP;
		else if (s > 'h80) s = (s - `SH_STEER_STEP < 'h80) ? 'h80 : s - `SH_STEER_STEP;
		else if (s < 'h80) s = (s + `SH_STEER_STEP > 'h80) ? 'h80 : s + `SH_STEER_STEP;
		return {g[7:0], s[7:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	always @(negedge clk_sys) begin
		if (ctrl_check) begin
			check_value("gas", 32'(gas), 32'(exp_gas));
			check_value("steering", 32'(steering), 32'(exp_steer));
		end
	end

	// ========================================
	// stimulus helpers
	// ========================================

	task automatic write_byte(input int a, input logic [7:0] d, input logic [7:0] idx);
		ioctl_addr = dl_addr_t'(a);
		ioctl_dout = d;
		ioctl_index = idx;
		ioctl_wr = 1'b1;
		@(posedge clk_sys);
		#1 ioctl_wr = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
	endtask

	// count low cycles up to the pulse, then expect a single high cycle
	task automatic measure_pulse(output int low_cycles);
		low_cycles = 0;
		while (!core_reset) begin
			low_cycles++;
			@(negedge clk_sys);
		end
		@(negedge clk_sys);
		check_value("core_reset", 32'(core_reset), 32'd0);
	endtask

	task automatic run_frame(input logic [3:0] pad);
		{gas_up, gas_down, steer_left, steer_right} = pad;
		vsync = 1'b1;
		@(posedge clk_sys);
		#1 {exp_gas, exp_steer} = ref_controls({exp_gas, exp_steer}, pad);
		vsync = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
	endtask

	task automatic press_shift(input logic with_coin, input logic exp_state);
		shift_button = 1'b1;
		coin = with_coin;
		@(posedge clk_sys);
		#1 check_value("shift_state", 32'(shift_state), 32'(exp_state));
		shift_button = 1'b0;
		coin = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	initial begin
		int v;
		int n;
		int pad;
		int low;
		cycles = 0;
		lfsr = 32'hc86d0174;
		ctrl_check = 1'b0;
		{reset, user_reset, ioctl_download, ioctl_wr} = 4'b1000;
		ioctl_index = '0;
		ioctl_dout = '0;
		ioctl_addr = '0;
		prog_addr = '0;
		sprite_addr = '0;
		{vsync, gas_up, gas_down, steer_left, steer_right, shift_button, coin} = '0;
		for (int a = 0; a < IMG_LEN; a++) begin
			v = take_bits(8);
			img[a] = v[7:0];
		end
		repeat (5) @(posedge clk_sys);
		#1 reset = 1'b0;
		@(negedge clk_sys);
		check_value("core_reset", 32'(core_reset), 32'd1);

		// full image, then bytes past the sprite end that must be dropped
		@(posedge clk_sys);
		#1 ioctl_download = 1'b1;
		for (int a = 0; a < IMG_LEN; a++) begin
			write_byte(a, img[a], 8'd0);
		end
		for (int a = IMG_LEN; a < IMG_LEN + 16; a++) begin
			write_byte(a, 8'h5a, 8'd0);
		end
		write_byte('h20, ~img['h20], 8'd1);
		img['h21] = ~img['h21];
		write_byte('h21, img['h21], 8'd0);
		prog_addr = 16'h0010;
		@(posedge clk_sys);
		#1 check_value("prog_q", 32'(prog_q), 32'(ref_prog_word('h10)));
		check_value("core_reset", 32'(core_reset), 32'd1);

		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_value("core_reset", 32'(core_reset), 32'd1);
		@(negedge clk_sys);
		measure_pulse(low);
		check_value("core_reset low cycles", 32'(low), 32'(`SH_SECOND_RESET_DELAY));

		@(posedge clk_sys);
		#1;
		for (int w = 0; w < 'hc000; w++) begin
			prog_addr = bank_addr_t'(w);
			@(posedge clk_sys);
			#1 check_value("prog_q", 32'(prog_q), 32'(ref_prog_word(w)));
		end
		for (int i = 0; i < 32768; i++) begin
			sprite_addr = sprite_addr_t'(i);
			@(posedge clk_sys);
			#1 check_value("sprite_q", sprite_q, ref_sprite_word(i));
		end

		exp_gas = 8'h00;
		exp_steer = `SH_STEER_CENTER;
		ctrl_check = 1'b1;
		repeat (35) run_frame(4'b1000);
		repeat (35) run_frame(4'b0100);
		repeat (40) run_frame(4'b0001);
		repeat (40) run_frame(4'b0000);
		repeat (40) run_frame(4'b0010);
		repeat (40) run_frame(4'b0000);
		repeat (48) begin
			pad = take_bits(4);
			n = take_bits(4);
			repeat (n + 1) run_frame(pad[3:0]);
		end
		// leave both levels away from their rest values
		repeat (40) run_frame(4'b1001);

		press_shift(1'b0, 1'b1);
		press_shift(1'b0, 1'b0);
		// coin wins over a press that would raise the gear
		press_shift(1'b1, 1'b0);
		press_shift(1'b0, 1'b1);
		press_shift(1'b1, 1'b0);
		press_shift(1'b0, 1'b1);

		ctrl_check = 1'b0;
		user_reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1 check_value("core_reset", 32'(core_reset), 32'd1);
		check_value("gas", 32'(gas), 32'd0);
		check_value("steering", 32'(steering), 32'(`SH_STEER_CENTER));
		check_value("shift_state", 32'(shift_state), 32'd0);
		user_reset = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
		measure_pulse(low);
		check_value("core_reset low cycles", 32'(low), 32'(`SH_SECOND_RESET_DELAY));
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: spy_hunter_io.f
+incdir+logic
logic/spy_hunter_pkg.sv
logic/rom_loader.sv
logic/rom_store.sv
logic/reset_sequencer.sv
logic/driver_controls.sv
logic/spy_hunter_io.sv
test/spy_hunter_io_assert.sv
test/tb_spy_hunter_io.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spy_hunter_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_spy_hunter_io \
	-f spy_hunter_io.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
